// ==== Makefile ====
TOP := mips_cpu_bus_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build folder"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::op_t        op,
    input  mips_pkg::word_t      data_rs,
    input  mips_pkg::word_t      data_rt,
    input  logic [15:0]          immediate,
    input  logic [4:0]           shamt,
    output logic                 write_enable,
    output mips_pkg::word_t      result
);
    import mips_pkg::*;

    word_t imm_sext;  // Arithmetic and compare
    word_t imm_zext;  // Logic forms
    logic  produces;  // Op writes a register from here

    assign imm_sext = {{16{immediate[15]}}, immediate};
    assign imm_zext = {16'h0000, immediate};

    always_comb begin
        produces = 1'b1;
        result   = '0;
        case (op)
            OP_ADDU:  result = data_rs + data_rt;
            OP_ADDIU: result = data_rs + imm_sext;
            OP_SUBU:  result = data_rs - data_rt;
            OP_AND:   result = data_rs & data_rt;
            OP_ANDI:  result = data_rs & imm_zext;
            OP_OR:    result = data_rs | data_rt;
            OP_ORI:   result = data_rs | imm_zext;
            OP_XOR:   result = data_rs ^ data_rt;
            OP_XORI:  result = data_rs ^ imm_zext;
            OP_SLT:   result = {31'd0, $signed(data_rs) < $signed(data_rt)};
            OP_SLTU:  result = {31'd0, data_rs < data_rt};
            OP_SLTI:  result = {31'd0, $signed(data_rs) < $signed(imm_sext)};
            OP_SLTIU: result = {31'd0, data_rs < imm_sext};  // Sign-extended, unsigned compare
            OP_SLL:   result = data_rt << shamt;
            OP_SRL:   result = data_rt >> shamt;
            OP_SRA:   result = $signed(data_rt) >>> shamt;
            OP_LUI:   result = {immediate, 16'h0000};
            default:  produces = 1'b0;  // Memory, branch, jump, no-op
        endcase
    end

    assign write_enable = (state == EXEC) && produces;

endmodule

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  mips_pkg::word_t instruction,
    output logic [4:0]      rs,
    output logic [4:0]      rt,
    output logic [4:0]      rd,
    output logic [4:0]      shamt,
    output logic [15:0]     immediate,
    output logic [25:0]     jump_target,
    output mips_pkg::op_t   op
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       r_type;

    assign opcode      = instruction[31:26];
    assign funct       = instruction[5:0];
    assign r_type      = (opcode == 6'h00);
    assign rs          = instruction[25:21];
    assign rt          = instruction[20:16];
    assign shamt       = instruction[10:6];
    assign immediate   = instruction[15:0];
    assign jump_target = instruction[25:0];

    // Destination is rd for R-type, rt for immediate forms and lw
    assign rd = r_type ? instruction[15:11] : instruction[20:16];

    always_comb begin
        op = OP_NONE;  // Anything unmatched is a no-op
        if (r_type) begin
            case (funct)
                6'h00:   op = OP_SLL;
                6'h02:   op = OP_SRL;
                6'h03:   op = OP_SRA;
                6'h08:   op = OP_JR;
                6'h21:   op = OP_ADDU;
                6'h23:   op = OP_SUBU;
                6'h24:   op = OP_AND;
                6'h25:   op = OP_OR;
                6'h26:   op = OP_XOR;
                6'h2a:   op = OP_SLT;
                6'h2b:   op = OP_SLTU;
                default: op = OP_NONE;
            endcase
        end else begin
            case (opcode)
                6'h02:   op = OP_J;
                6'h03:   op = OP_JAL;
                6'h04:   op = OP_BEQ;
                6'h05:   op = OP_BNE;
                6'h09:   op = OP_ADDIU;
                6'h0a:   op = OP_SLTI;
                6'h0b:   op = OP_SLTIU;
                6'h0c:   op = OP_ANDI;
                6'h0d:   op = OP_ORI;
                6'h0e:   op = OP_XORI;
                6'h0f:   op = OP_LUI;
                6'h23:   op = OP_LW;
                6'h2b:   op = OP_SW;
                default: op = OP_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== load_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::op_t        op,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      data_rs,
    input  mips_pkg::word_t      data_rt,
    input  logic [15:0]          immediate,
    output mips_pkg::word_t      instruction,
    output logic                 stall,
    output logic                 reg_write_enable,
    output mips_pkg::word_t      reg_write_data,
    output mips_pkg::word_t      address,
    output mips_pkg::word_t      writedata,
    output logic                 read,
    output logic                 write,
    output logic [3:0]           byteenable,
    input  logic                 waitrequest,
    input  mips_pkg::word_t      readdata
);
    import mips_pkg::*;

    word_t mem_addr;  // Effective address for lw and sw
    logic  fetching;
    logic  loading;
    logic  storing;

    assign mem_addr = data_rs + {{16{immediate[15]}}, immediate};
    assign fetching = (state == FETCH);
    assign loading  = (state == MEM) && (op == OP_LW);
    assign storing  = (state == MEM) && (op == OP_SW);

    // Strobes held until waitrequest drops
    assign read       = fetching || loading;
    assign write      = storing;
    assign address    = fetching ? pc : mem_addr;
    assign writedata  = storing ? data_rt : '0;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;  // Word accesses only

    assign stall = (read || write) && waitrequest;

    // Readdata valid the same cycle waitrequest is low
    assign reg_write_enable = loading && !waitrequest;
    assign reg_write_data   = readdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instruction <= '0;  // Decodes as sll $0, a no-op
        end else if (fetching && !waitrequest) begin
            instruction <= readdata;  // Fetch completes
        end
    end

endmodule

`default_nettype wire

// ==== mips_cpu_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,

    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable
);
    import mips_pkg::*;

    cpu_state_t  state;
    op_t         op;
    word_t       instruction;  // Latched by load_store at fetch
    word_t       pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] immediate;
    logic [25:0] jump_target;
    logic        stall;
    word_t       data_rs;
    word_t       data_rt;

    // Three writeback sources into the regfile
    logic  write_enable_alu;
    word_t write_data_alu;
    logic  write_enable_ld;
    word_t write_data_ld;
    logic  write_enable_link;
    word_t write_data_link;

    decode u_decode (
        .instruction (instruction),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .shamt       (shamt),
        .immediate   (immediate),
        .jump_target (jump_target),
        .op          (op)
    );

    regfile u_regfile (
        .clk               (clk),
        .rst_n             (rst_n),
        .addr_rs           (rs),
        .addr_rt           (rt),
        .addr_rd           (rd),
        .write_enable_alu  (write_enable_alu),
        .write_enable_ld   (write_enable_ld),
        .write_enable_link (write_enable_link),
        .write_data_alu    (write_data_alu),
        .write_data_ld     (write_data_ld),
        .write_data_link   (write_data_link),
        .read_data_rs      (data_rs),
        .read_data_rt      (data_rt),
        .v0                (register_v0)
    );

    next_instruction u_next_instruction (
        .clk               (clk),
        .rst_n             (rst_n),
        .op                (op),
        .data_rs           (data_rs),
        .data_rt           (data_rt),
        .immediate         (immediate),
        .jump_target       (jump_target),
        .stall             (stall),
        .state             (state),
        .pc                (pc),
        .write_enable_link (write_enable_link),
        .write_data_link   (write_data_link),
        .active            (active)
    );

    alu u_alu (
        .state        (state),
        .op           (op),
        .data_rs      (data_rs),
        .data_rt      (data_rt),
        .immediate    (immediate),
        .shamt        (shamt),
        .write_enable (write_enable_alu),
        .result       (write_data_alu)
    );

    load_store u_load_store (
        .clk              (clk),
        .rst_n            (rst_n),
        .state            (state),
        .op               (op),
        .pc               (pc),
        .data_rs          (data_rs),
        .data_rt          (data_rt),
        .immediate        (immediate),
        .instruction      (instruction),
        .stall            (stall),
        .reg_write_enable (write_enable_ld),
        .reg_write_data   (write_data_ld),
        .address          (address),
        .writedata        (writedata),
        .read             (read),
        .write            (write),
        .byteenable       (byteenable),
        .waitrequest      (waitrequest),
        .readdata         (readdata)
    );

endmodule

`default_nettype wire

// ==== mips_cpu_bus_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            read,
    input logic            write,
    input logic            waitrequest,
    input mips_pkg::word_t address,
    input logic            active
);
    import mips_pkg::*;

    // One direction per access
    a_read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write))
        else $error("read and write high in the same cycle");

    // Request held through wait states
    a_address_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((read || write) && waitrequest) |=> $stable(address))
        else $error("address changed while waitrequest was high");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !active |=> !active)
        else $error("active rose again without a reset");

endmodule

bind mips_cpu_bus mips_cpu_bus_assert u_bus_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .active      (active)
);

`default_nettype wire

// ==== mips_cpu_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            active,
    input  mips_pkg::word_t register_v0,
    input  logic            write,
    input  logic            waitrequest,
    input  mips_pkg::word_t address,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    input  int              row_id,
    input  logic            random_waits,
    input  mips_pkg::word_t expected_v0,
    input  logic            expect_store,
    input  mips_pkg::word_t expected_addr,
    input  mips_pkg::word_t expected_data,
    input  logic            done,
    output int              pass_count,
    output int              fail_count
);
    import mips_pkg::*;

    int    passes = 0;
    int    fails = 0;
    logic  active_q = 1'b0;
    logic  reported = 1'b0;
    logic  store_seen = 1'b0;  // A write completed this run
    word_t seen_addr;
    word_t seen_data;
    logic  [3:0] seen_be;
    word_t zero_wait_v0 [8];    // Results of the zero-wait pass

    assign pass_count = passes;
    assign fail_count = fails;

    always @(posedge clk) begin
        logic ok;
        ok = 1'b1;
        active_q <= active;
        if (!rst_n) begin
            store_seen <= 1'b0;
        end else begin
            if (write && !waitrequest) begin
                store_seen <= 1'b1;
                seen_addr  <= address;
                seen_data  <= writedata;
                seen_be    <= byteenable;
            end
            if (active_q && !active) begin  // Halt reached
                if (register_v0 !== expected_v0) begin
                    $display("CHECK FAILED at %0t ns: row %0d v0 expected %h got %h",
                             $time, row_id, expected_v0, register_v0);
                    ok = 1'b0;
                end
                if (expect_store && (!store_seen || seen_addr !== expected_addr ||
                    seen_data !== expected_data || seen_be !== 4'b1111)) begin
                    $display("CHECK FAILED at %0t ns: row %0d sw exp %h at %h got %h at %h be %b",
                             $time, row_id, expected_data, expected_addr,
                             seen_data, seen_addr, seen_be);
                    ok = 1'b0;
                end
                if (random_waits && register_v0 !== zero_wait_v0[row_id]) begin
                    $display("CHECK FAILED at %0t ns: row %0d v0 %h with waits, %h without",
                             $time, row_id, register_v0, zero_wait_v0[row_id]);
                    ok = 1'b0;
                end
                if (!random_waits) begin
                    zero_wait_v0[row_id] <= register_v0;
                end
                $display("row %0d, %s waits: %s", row_id,
                         random_waits ? "random" : "no", ok ? "PASS" : "FAIL");
                if (ok) begin
                    passes <= passes + 1;
                end else begin
                    fails <= fails + 1;
                end
            end
        end
        if (done && !reported) begin
            $display("%0d tests run, %0d passed, %0d failed", passes + fails, passes, fails);
            reported <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== mips_cpu_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module mips_cpu_bus_tb;
    import mips_pkg::*;

    localparam int num_rows    = 5;
    localparam int prog_len    = 16;
    localparam int mem_words   = 64;
    localparam int cycle_limit = 2 * num_rows * prog_len * 12;  // Both wait modes
    localparam logic [31:0] reset_vec = `MIPS_RESET_VECTOR;
    localparam logic [31:0] data_addr = 32'h0000_0080;          // Preload slot
    localparam int prog_base = int'(reset_vec[7:2]);

    logic  clk = 1'b0;
    logic  rst_n;
    logic  waitrequest = 1'b0;
    word_t readdata;
    word_t address;
    word_t writedata;
    logic  read;
    logic  write;
    logic  [3:0] byteenable;
    logic  active;
    word_t register_v0;

    // Memory model loaded from image while reset is low
    word_t mem   [mem_words] = '{default: '0};
    word_t image [mem_words] = '{default: '0};

    // One program table row per test
    word_t prog       [num_rows][prog_len];
    word_t preload    [num_rows];
    word_t expect_v0  [num_rows];
    logic  has_store  [num_rows];
    word_t store_addr [num_rows];
    word_t store_data [num_rows];

    // Current row as seen by the checker
    int    row_id = 0;
    logic  random_waits = 1'b0;
    word_t expected_v0 = '0;
    logic  expect_store = 1'b0;
    word_t expected_addr = '0;
    word_t expected_data = '0;
    logic  done = 1'b0;
    int    pass_count;
    int    fail_count;

    logic [31:0] seed = 32'd75;
    int          wait_run = 0;  // Consecutive wait cycles
    int          cycles = 0;

    always #10 clk = ~clk;

    mips_cpu_bus uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .write       (write),
        .read        (read),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    mips_cpu_bus_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .active        (active),
        .register_v0   (register_v0),
        .write         (write),
        .waitrequest   (waitrequest),
        .address       (address),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .row_id        (row_id),
        .random_waits  (random_waits),
        .expected_v0   (expected_v0),
        .expect_store  (expect_store),
        .expected_addr (expected_addr),
        .expected_data (expected_data),
        .done          (done),
        .pass_count    (pass_count),
        .fail_count    (fail_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // MIPS encodings
    function automatic word_t r_instr(input int rs, input int rt, input int rd,
                                      input int sh, input int funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct[5:0]};
    endfunction

    function automatic word_t i_instr(input int opcode, input int rs, input int rt,
                                      input int imm);
        return {opcode[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t j_instr(input int opcode, input word_t target);
        return {opcode[5:0], target[27:2]};  // Upper bits come from PC+4
    endfunction

    // Data valid only in the cycle a read completes
    assign readdata = (read && !waitrequest) ? mem[address[7:2]] : 32'hffff_ffff;

    always @(posedge clk) begin
        word_t merged;
        if (!rst_n) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= image[i];
            end
        end else if (write && !waitrequest) begin
            merged = mem[address[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    merged[8*b +: 8] = writedata[8*b +: 8];
                end
            end
            mem[address[7:2]] <= merged;
        end
    end

    // At most 3 random waits in a row
    always @(posedge clk) begin
        #1;
        seed = lcg_next(seed);
        if (random_waits && wait_run < 3 && seed[18:16] < 3'd3) begin
            waitrequest <= 1'b1;
            wait_run    <= wait_run + 1;
        end else begin
            waitrequest <= 1'b0;
            wait_run    <= 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the processor never halted within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic build_table();
        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < prog_len; i++) begin
                prog[r][i] = '0;  // sll $0 no-op
            end
            preload[r]    = '0;
            has_store[r]  = 1'b0;
            store_addr[r] = '0;
            store_data[r] = '0;
        end
        // Register ALU ops
        prog[0][0]  = i_instr('h0d, 0, 8, 'h1234);    // ori t0 = 0x1234
        prog[0][1]  = i_instr('h0d, 0, 9, 'h00f0);    // ori t1 = 0xf0
        prog[0][2]  = r_instr(8, 9, 10, 0, 'h21);     // addu t2 = 0x1324
        prog[0][3]  = r_instr(8, 9, 11, 0, 'h23);     // subu t3 = 0x1144
        prog[0][4]  = r_instr(8, 9, 12, 0, 'h24);     // and t4 = 0x30
        prog[0][5]  = r_instr(10, 12, 2, 0, 'h25);    // or v0 = 0x1334
        prog[0][6]  = r_instr(2, 11, 2, 0, 'h26);     // xor v0 = 0x270
        prog[0][7]  = r_instr(0, 9, 14, 0, 'h23);     // subu t6 = -0xf0
        prog[0][8]  = r_instr(14, 9, 13, 0, 'h2a);    // slt t5 = 1
        prog[0][9]  = r_instr(14, 9, 15, 0, 'h2b);    // sltu t7 = 0
        prog[0][10] = r_instr(9, 14, 24, 0, 'h2b);    // sltu t8 = 1
        prog[0][11] = r_instr(2, 13, 2, 0, 'h21);     // addu v0 += t5
        prog[0][12] = r_instr(2, 15, 2, 0, 'h23);     // subu v0 -= t7
        prog[0][13] = r_instr(2, 24, 2, 0, 'h21);     // addu v0 += t8
        prog[0][14] = r_instr(0, 0, 0, 0, 'h08);      // jr $0
        expect_v0[0] = 32'h0000_0272;
        // Immediates, shifts, lui
        prog[1][0]  = i_instr('h09, 0, 8, -3);        // addiu t0 = 0xfffffffd
        prog[1][1]  = i_instr('h0c, 8, 9, 'hff00);    // andi t1 = 0xff00
        prog[1][2]  = i_instr('h0d, 9, 10, 'h8001);   // ori t2 = 0xff01
        prog[1][3]  = i_instr('h0e, 10, 11, 'hffff);  // xori t3 = 0xfe
        prog[1][4]  = i_instr('h0a, 8, 12, -2);       // slti t4 = 1
        prog[1][5]  = i_instr('h0b, 11, 13, -1);      // sltiu t5 = 1
        prog[1][6]  = i_instr('h0f, 0, 14, 'h8765);   // lui t6
        prog[1][7]  = i_instr('h0d, 14, 14, 'h4321);  // t6 = 0x87654321
        prog[1][8]  = r_instr(0, 14, 15, 4, 'h03);    // sra t7 = 0xf8765432
        prog[1][9]  = r_instr(0, 14, 24, 8, 'h02);    // srl t8 = 0x00876543
        prog[1][10] = r_instr(0, 11, 25, 4, 'h00);    // sll t9 = 0xfe0
        prog[1][11] = r_instr(15, 24, 2, 0, 'h26);    // xor v0 = 0xf8f13171
        prog[1][12] = r_instr(2, 25, 2, 0, 'h21);
        prog[1][13] = r_instr(2, 12, 2, 0, 'h21);
        prog[1][14] = r_instr(2, 13, 2, 0, 'h21);
        prog[1][15] = r_instr(0, 0, 0, 0, 'h08);      // jr $0
        expect_v0[1] = 32'hf8f1_4153;
        // Memory round trip through 0x84
        prog[2][0]  = i_instr('h23, 0, 8, 'h0080);    // lw t0, preload
        prog[2][1]  = i_instr('h09, 8, 8, 'h0100);    // addiu t0 += 0x100
        prog[2][2]  = i_instr('h0d, 0, 9, 'h0040);    // ori t1 = 0x40
        prog[2][3]  = i_instr('h2b, 9, 8, 'h0044);    // sw t0, 0x44(t1)
        prog[2][4]  = i_instr('h23, 9, 2, 'h0044);    // lw v0, 0x44(t1)
        prog[2][5]  = r_instr(0, 0, 0, 0, 'h08);
        preload[2]    = 32'h1122_3344;
        expect_v0[2]  = 32'h1122_3444;
        has_store[2]  = 1'b1;
        store_addr[2] = data_addr + 32'd4;
        store_data[2] = 32'h1122_3444;
        // Each bit of v0 marks one branch path
        prog[3][0]  = i_instr('h0d, 0, 8, 5);
        prog[3][1]  = i_instr('h0d, 0, 9, 5);
        prog[3][2]  = i_instr('h0d, 0, 2, 0);
        prog[3][3]  = i_instr('h04, 8, 9, 1);         // beq taken
        prog[3][4]  = i_instr('h0d, 2, 2, 1);         // Skipped
        prog[3][5]  = i_instr('h05, 8, 9, 1);         // bne not taken
        prog[3][6]  = i_instr('h0d, 2, 2, 2);
        prog[3][7]  = i_instr('h05, 8, 0, 1);         // bne taken
        prog[3][8]  = i_instr('h0d, 2, 2, 4);         // Skipped
        prog[3][9]  = i_instr('h04, 8, 0, 1);         // beq not taken
        prog[3][10] = i_instr('h0d, 2, 2, 8);
        prog[3][11] = r_instr(0, 0, 0, 0, 'h08);
        expect_v0[3] = 32'h0000_000a;
        // j, jal and jr $ra
        prog[4][0]  = i_instr('h0d, 0, 2, 'h10);
        prog[4][1]  = j_instr('h02, reset_vec + 32'd12);  // j over word 2
        prog[4][2]  = i_instr('h0d, 2, 2, 1);         // Skipped
        prog[4][3]  = j_instr('h03, reset_vec + 32'd28);  // jal to word 7
        prog[4][4]  = i_instr('h0d, 2, 2, 4);         // Return lands here
        prog[4][5]  = r_instr(2, 31, 2, 0, 'h21);     // addu v0 += ra
        prog[4][6]  = r_instr(0, 0, 0, 0, 'h08);
        prog[4][7]  = i_instr('h0d, 2, 2, 2);
        prog[4][8]  = r_instr(31, 0, 0, 0, 'h08);     // jr $ra
        expect_v0[4] = 32'h0000_0016 + reset_vec + 32'd16;
    endtask

    task automatic run_row(input int row, input logic waits);
        @(posedge clk);
        #1;
        rst_n         = 1'b0;
        random_waits  = waits;
        row_id        = row;
        expected_v0   = expect_v0[row];
        expect_store  = has_store[row];
        expected_addr = store_addr[row];
        expected_data = store_data[row];
        for (int i = 0; i < mem_words; i++) begin
            image[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            image[prog_base + i] = prog[row][i];
        end
        image[int'(data_addr[7:2])] = preload[row];
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        while (active) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);  // Checker logs the row meanwhile
    endtask

    initial begin
        rst_n = 1'b0;
        build_table();
        for (int mode = 0; mode < 2; mode++) begin  // Zero waits first
            for (int r = 0; r < num_rows; r++) begin
                run_row(r, mode == 1);
            end
        end
        #1;
        done = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        if (fail_count == 0 && pass_count == 2 * num_rows) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;  // Data and address word

    // Processor phase
    typedef enum logic [1:0] {
        FETCH = 2'd0,  // Instruction read over the bus
        EXEC  = 2'd1,  // ALU, branch and jump
        MEM   = 2'd2,  // lw and sw only
        HALT  = 2'd3   // Parked after jump to zero
    } cpu_state_t;

    // One code per supported instruction
    typedef enum logic [4:0] {
        OP_NONE,   // Illegal or unsupported, runs as no-op
        OP_ADDU,
        OP_ADDIU,
        OP_SUBU,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_SLT,
        OP_SLTU,
        OP_SLTI,
        OP_SLTIU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JAL,
        OP_JR
    } op_t;

endpackage

`default_nettype wire

// ==== mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address out of reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Jumping here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

`define MIPS_REG_V0 5'd2   // Result register seen at top level
`define MIPS_REG_RA 5'd31  // Link register for jal

`endif

// ==== next_instruction.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module next_instruction (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::op_t        op,
    input  mips_pkg::word_t      data_rs,
    input  mips_pkg::word_t      data_rt,
    input  logic [15:0]          immediate,
    input  logic [25:0]          jump_target,
    input  logic                 stall,
    output mips_pkg::cpu_state_t state,
    output mips_pkg::word_t      pc,
    output logic                 write_enable_link,
    output mips_pkg::word_t      write_data_link,
    output logic                 active
);
    import mips_pkg::*;

    cpu_state_t state_next;
    word_t      pc_plus4;
    word_t      pc_next;
    logic       taken;    // Branch condition met
    logic       is_jump;  // j, jal or jr

    assign pc_plus4 = pc + 32'd4;
    assign is_jump  = (op == OP_J) || (op == OP_JAL) || (op == OP_JR);
    assign taken    = ((op == OP_BEQ) && (data_rs == data_rt)) ||
                      ((op == OP_BNE) && (data_rs != data_rt));

    always_comb begin
        pc_next = pc_plus4;  // Default fall-through
        if (taken) begin
            pc_next = pc_plus4 + {{14{immediate[15]}}, immediate, 2'b00};
        end else if (op == OP_JR) begin
            pc_next = data_rs;
        end else if (is_jump) begin
            pc_next = {pc_plus4[31:28], jump_target, 2'b00};  // Region of next PC
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH: state_next = EXEC;
            EXEC: begin
                if (is_jump && pc_next == `MIPS_HALT_ADDR) begin
                    state_next = HALT;  // Halt convention
                end else if (op == OP_LW || op == OP_SW) begin
                    state_next = MEM;
                end else begin
                    state_next = FETCH;
                end
            end
            MEM:     state_next = FETCH;
            default: state_next = HALT;  // Stays parked until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= `MIPS_RESET_VECTOR;
        end else if (!stall) begin  // Bus wait freezes everything
            state <= state_next;
            if (state == EXEC) begin
                pc <= pc_next;
            end
        end
    end

    // Link written during EXEC, regfile forces $ra
    assign write_enable_link = (state == EXEC) && (op == OP_JAL);
    assign write_data_link   = pc_plus4;

    assign active = (state != HALT);

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      addr_rs,
    input  logic [4:0]      addr_rt,
    input  logic [4:0]      addr_rd,
    input  logic            write_enable_alu,
    input  logic            write_enable_ld,
    input  logic            write_enable_link,
    input  mips_pkg::word_t write_data_alu,
    input  mips_pkg::word_t write_data_ld,
    input  mips_pkg::word_t write_data_link,
    output mips_pkg::word_t read_data_rs,
    output mips_pkg::word_t read_data_rt,
    output mips_pkg::word_t v0
);
    import mips_pkg::*;

    word_t regs [32];

    // Asynchronous reads, $zero never written so reads back zero
    assign read_data_rs = regs[addr_rs];
    assign read_data_rt = regs[addr_rt];
    assign v0           = regs[`MIPS_REG_V0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable_link) begin
            regs[`MIPS_REG_RA] <= write_data_link;  // jal return address
        end else if (write_enable_alu && addr_rd != 5'd0) begin
            regs[addr_rd] <= write_data_alu;
        end else if (write_enable_ld && addr_rd != 5'd0) begin
            regs[addr_rd] <= write_data_ld;         // lw writeback
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
mips_pkg.sv
decode.sv
regfile.sv
next_instruction.sv
alu.sv
load_store.sv
mips_cpu_bus.sv
mips_cpu_bus_checker.sv
mips_cpu_bus_assert.sv
mips_cpu_bus_tb.sv
